//--- Bender.yml
package:
  name: load_unit

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/load_unit_pkg.sv
      - logic/load_ctrl_fsm.sv
      - logic/load_buffer.sv
      - logic/load_align.sv
      - logic/load_unit.sv
  - target: simulation
    files:
      - verif/tb_load_unit.sv

//--- logic/load_align.sv
// Load data alignment
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  load_unit_pkg::xlen_t      rdata_i,
    input  load_unit_pkg::byte_off_t  offset_i,
    input  load_unit_pkg::load_op_e   op_i,
    output load_unit_pkg::xlen_t      result_o
);
    import load_unit_pkg::*;

    localparam int unsigned XLEN   = $bits(xlen_t);
    localparam int unsigned NBYTES = XLEN / 8;

    xlen_t             shifted;
    logic [NBYTES-1:0] sign_bits;
    byte_off_t         sign_idx;
    logic              is_signed;
    logic              sign_bit;

    // move the addressed field down to bit 0
    assign shifted = rdata_i >> {offset_i, 3'b000};

    // top bit of every byte in the raw word
    for (genvar i = 0; i < NBYTES; i++) begin : gen_sign_bits
        assign sign_bits[i] = rdata_i[(i + 1) * 8 - 1];
    end

    // the sign lives in the highest byte of the field
    always_comb begin
        case (op_i)
            LW, LWU:  sign_idx = offset_i + 3'd3;
            LH, LHU:  sign_idx = offset_i + 3'd1;
            default:  sign_idx = offset_i;
        endcase
    end

    assign is_signed = op_i inside {LW, LH, LB};

    // picked from the unshifted word so it settles in parallel with the shifter
    assign sign_bit = is_signed & sign_bits[sign_idx];

    // --------------------
    // result mux
    // --------------------
    always_comb begin
        case (op_i)
            LW, LWU:  result_o = {{(XLEN - 32){sign_bit}}, shifted[31:0]};
            LH, LHU:  result_o = {{(XLEN - 16){sign_bit}}, shifted[15:0]};
            LB, LBU:  result_o = {{(XLEN - 8){sign_bit}}, shifted[7:0]};
            default:  result_o = shifted;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/load_buffer.sv
// Outstanding load table
`timescale 1ns/1ps
`default_nettype none

`include "load_unit_cfg.svh"

module load_buffer (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire logic                     flush_i,
    // request side
    input  wire logic                     data_req_i,
    input  wire logic                     data_gnt_i,
    input  wire logic                     kill_req_i,
    input  load_unit_pkg::trans_id_t      trans_id_i,
    input  load_unit_pkg::byte_off_t      offset_i,
    input  load_unit_pkg::load_op_e       op_i,
    output logic                          ldbuf_full_o,
    output load_unit_pkg::ldbuf_id_t      data_id_o,
    // response side
    input  wire logic                     data_rvalid_i,
    input  load_unit_pkg::ldbuf_id_t      data_rid_i,
    output logic                          valid_o,
    output load_unit_pkg::trans_id_t      trans_id_o,
    output load_unit_pkg::byte_off_t      rd_offset_o,
    output load_unit_pkg::load_op_e       rd_op_o
);
    import load_unit_pkg::*;

    localparam int unsigned NR = `LU_NR_LDBUF;

    logic [NR-1:0] valid_q, valid_d;
    // set for loads that were in flight when a flush came in
    logic [NR-1:0] flushed_q, flushed_d;
    trans_id_t     trans_id_q [NR];
    byte_off_t     offset_q   [NR];
    load_op_e      op_q       [NR];
    ldbuf_id_t     last_id_q;
    ldbuf_id_t     windex;
    logic          ldbuf_w;

    // a slot is taken whenever the cache accepts a request
    assign ldbuf_w      = data_req_i & data_gnt_i;
    assign ldbuf_full_o = &valid_q;
    // the slot number is the id the cache hands back with the response
    assign data_id_o    = windex;

    // lowest free slot, scanning down so the last hit is the lowest index
    always_comb begin
        windex = '0;
        for (int i = NR - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                windex = ldbuf_id_t'(i);
            end
        end
    end

    // --------------------
    // slot bookkeeping
    // --------------------
    always_comb begin
        valid_d   = valid_q;
        flushed_d = flushed_q;
        if (flush_i) begin
            flushed_d = flushed_q | valid_q;
        end
        if (data_rvalid_i) begin
            valid_d[data_rid_i] = 1'b0;
        end
        // a fresh entry never inherits the flushed mark of the old one
        if (ldbuf_w) begin
            valid_d[windex]   = 1'b1;
            flushed_d[windex] = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q   <= '0;
            flushed_q <= '0;
            last_id_q <= '0;
        end else begin
            valid_q   <= valid_d;
            flushed_q <= flushed_d;
            if (ldbuf_w) begin
                last_id_q <= windex;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ldbuf_w) begin
            trans_id_q[windex] <= trans_id_i;
            offset_q[windex]   <= offset_i;
            op_q[windex]       <= op_i;
        end
    end

    // --------------------
    // response side
    // --------------------
    assign trans_id_o  = trans_id_q[data_rid_i];
    assign rd_offset_o = offset_q[data_rid_i];
    assign rd_op_o     = op_q[data_rid_i];

    // a kill only ever targets the request written last, which is the one in the tag phase
    assign valid_o = data_rvalid_i && !flushed_q[data_rid_i] &&
                     ((last_id_q != data_rid_i) || !kill_req_i);

    // the cache only answers requests this table still holds
    a_rid_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_rvalid_i |-> valid_q[data_rid_i]);

    // the FSM must hold back while every slot is taken
    a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ldbuf_w |-> !ldbuf_full_o);

endmodule

`default_nettype wire

//--- logic/load_ctrl_fsm.sv
// Load request control
`timescale 1ns/1ps
`default_nettype none

module load_ctrl_fsm (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      flush_i,
    // issue side
    input  wire logic                      valid_i,
    input  load_unit_pkg::load_op_e        op_i,
    output logic                           pop_ld_o,
    // load buffer occupancy
    input  wire logic                      ldbuf_full_i,
    // store check and translation
    input  wire logic                      page_offset_matches_i,
    output logic                           translation_req_o,
    input  wire logic                      dtlb_hit_i,
    // cache request and tag phases
    output logic                           data_req_o,
    output load_unit_pkg::data_size_t      data_size_o,
    input  wire logic                      data_gnt_i,
    output logic                           tag_valid_o,
    output logic                           kill_req_o
);
    import load_unit_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_PAGE_OFFSET,
        WAIT_GNT,
        SEND_TAG,
        ABORT_TRANSACTION,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } state_e;

    state_e state_q, state_d;
    logic   try_start;

    // the size only depends on the operation the issuer is holding
    assign data_size_o = transfer_size(op_i);

    // --------------------
    // next state
    // --------------------
    always_comb begin
        state_d           = state_q;
        try_start         = 1'b0;
        pop_ld_o          = 1'b0;
        translation_req_o = 1'b0;
        data_req_o        = 1'b0;
        tag_valid_o       = 1'b0;
        kill_req_o        = 1'b0;

        case (state_q)
            IDLE: begin
                try_start = 1'b1;
            end

            // a store to the same page offset is still pending
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_matches_i) begin
                    state_d = WAIT_GNT;
                end
            end

            // hold the request until the cache arbiter takes it
            WAIT_GNT: begin
                translation_req_o = 1'b1;
                data_req_o        = 1'b1;
            end

            // the translation of the granted request was a hit
            SEND_TAG: begin
                tag_valid_o = 1'b1;
                state_d     = IDLE;
                // another load may start in this cycle
                try_start   = 1'b1;
            end

            // the TLB missed after the grant so the cache gets a kill with the tag
            ABORT_TRANSACTION: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = WAIT_TRANSLATION;
            end

            // keep asking until the page walk has filled the TLB
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end

            // kill whatever request might still be in the tag phase
            WAIT_FLUSH: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // a new load is only taken when its buffer slot is sure to exist
        if (try_start && valid_i && !ldbuf_full_i) begin
            // translation starts before the store check settles
            translation_req_o = 1'b1;
            if (page_offset_matches_i) begin
                state_d = WAIT_PAGE_OFFSET;
            end else begin
                data_req_o = 1'b1;
                state_d    = WAIT_GNT;
            end
        end

        // grant phase shared by a fresh start and by WAIT_GNT
        if (data_req_o && data_gnt_i) begin
            if (dtlb_hit_i) begin
                pop_ld_o = 1'b1;
                state_d  = SEND_TAG;
            end else begin
                state_d = ABORT_TRANSACTION;
            end
        end

        // flush wins over everything else
        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // assertions
    // --------------------

    // a pop needs a hit on a granted request and the tag follows one cycle later
    a_pop_then_tag: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_ld_o |-> (data_gnt_i && dtlb_hit_i) ##1 tag_valid_o);

    // tags back to back are only legal when a new request was granted with a hit
    a_tag_spacing: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (tag_valid_o && $past(tag_valid_o) && !kill_req_o)
        |-> $past(data_req_o && data_gnt_i && dtlb_hit_i));

endmodule

`default_nettype wire

//--- logic/load_unit.sv
// Load unit top level
`timescale 1ns/1ps
`default_nettype none

`include "load_unit_cfg.svh"

module load_unit (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire logic                     flush_i,
    // issue side
    input  wire logic                     valid_i,
    input  load_unit_pkg::vaddr_t         vaddr_i,
    input  load_unit_pkg::load_op_e       op_i,
    input  load_unit_pkg::trans_id_t      trans_id_i,
    output logic                          pop_ld_o,
    // result side
    output logic                          valid_o,
    output load_unit_pkg::trans_id_t      trans_id_o,
    output load_unit_pkg::xlen_t          result_o,
    // translation
    output logic                          translation_req_o,
    output load_unit_pkg::vaddr_t         vaddr_o,
    input  load_unit_pkg::paddr_t         paddr_i,
    input  wire logic                     dtlb_hit_i,
    // store check
    output load_unit_pkg::dc_index_t      page_offset_o,
    input  wire logic                     page_offset_matches_i,
    // data cache port
    output logic                          data_req_o,
    input  wire logic                     data_gnt_i,
    output load_unit_pkg::dc_index_t      address_index_o,
    output load_unit_pkg::data_size_t     data_size_o,
    output load_unit_pkg::ldbuf_id_t      data_id_o,
    output logic                          tag_valid_o,
    output load_unit_pkg::dc_tag_t        address_tag_o,
    output logic                          kill_req_o,
    input  wire logic                     data_rvalid_i,
    input  load_unit_pkg::ldbuf_id_t      data_rid_i,
    input  load_unit_pkg::xlen_t          data_rdata_i
);
    import load_unit_pkg::*;

    logic      ldbuf_full;
    byte_off_t rd_offset;
    load_op_e  rd_op;

    // --------------------
    // address slices
    // --------------------

    // the translation and the store check both look at the load being held
    assign vaddr_o         = vaddr_i;
    assign page_offset_o   = vaddr_i[11:0];
    // the index is untranslated and goes out with the request
    assign address_index_o = vaddr_i[`LU_DC_INDEX_W-1:0];
    // in the tag phase the TLB side still presents the translation of the granted load
    assign address_tag_o   = paddr_i[`LU_DC_TAG_W+`LU_DC_INDEX_W-1:`LU_DC_INDEX_W];

    load_ctrl_fsm i_ctrl (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .valid_i               (valid_i),
        .op_i                  (op_i),
        .pop_ld_o              (pop_ld_o),
        .ldbuf_full_i          (ldbuf_full),
        .page_offset_matches_i (page_offset_matches_i),
        .translation_req_o     (translation_req_o),
        .dtlb_hit_i            (dtlb_hit_i),
        .data_req_o            (data_req_o),
        .data_size_o           (data_size_o),
        .data_gnt_i            (data_gnt_i),
        .tag_valid_o           (tag_valid_o),
        .kill_req_o            (kill_req_o)
    );

    // the byte offset of the load is what the aligner needs later on
    load_buffer i_ldbuf (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .data_req_i    (data_req_o),
        .data_gnt_i    (data_gnt_i),
        .kill_req_i    (kill_req_o),
        .trans_id_i    (trans_id_i),
        .offset_i      (vaddr_i[$bits(byte_off_t)-1:0]),
        .op_i          (op_i),
        .ldbuf_full_o  (ldbuf_full),
        .data_id_o     (data_id_o),
        .data_rvalid_i (data_rvalid_i),
        .data_rid_i    (data_rid_i),
        .valid_o       (valid_o),
        .trans_id_o    (trans_id_o),
        .rd_offset_o   (rd_offset),
        .rd_op_o       (rd_op)
    );

    load_align i_align (
        .rdata_i  (data_rdata_i),
        .offset_i (rd_offset),
        .op_i     (rd_op),
        .result_o (result_o)
    );

endmodule

`default_nettype wire

//--- logic/load_unit_cfg.svh
// Load unit configuration
`ifndef LOAD_UNIT_CFG_SVH
`define LOAD_UNIT_CFG_SVH

// --------------------
// datapath widths
// --------------------

// width of one integer register and of one cache word
`define LU_XLEN 64

// sv39 virtual address
`define LU_VLEN 39

// physical address as seen by the data cache
`define LU_PLEN 56

// --------------------
// load tracking
// --------------------

// number of cache requests that may be outstanding at once
`define LU_NR_LDBUF 2

// width of the scoreboard id carried along with every load
`define LU_TRANS_ID_BITS 3

// --------------------
// data cache split
// --------------------

// the index is the untranslated page offset, so it can go out before the tag
`define LU_DC_INDEX_W 12
`define LU_DC_TAG_W 44

`endif

//--- logic/load_unit_pkg.sv
// Load unit types
`default_nettype none

`include "load_unit_cfg.svh"

package load_unit_pkg;

    // --------------------
    // widths with a meaning
    // --------------------

    typedef logic [`LU_XLEN-1:0]          xlen_t;
    typedef logic [`LU_VLEN-1:0]          vaddr_t;
    typedef logic [`LU_PLEN-1:0]          paddr_t;
    typedef logic [`LU_TRANS_ID_BITS-1:0] trans_id_t;

    // slot index into the load buffer, which doubles as the cache request id
    typedef logic [(`LU_NR_LDBUF > 1 ? $clog2(`LU_NR_LDBUF) : 1)-1:0] ldbuf_id_t;

    typedef logic [`LU_DC_INDEX_W-1:0] dc_index_t;
    typedef logic [`LU_DC_TAG_W-1:0]   dc_tag_t;

    // byte position of the load inside one aligned word
    typedef logic [$clog2(`LU_XLEN/8)-1:0] byte_off_t;

    // size code on the cache port, 0 is a byte and 3 a double word
    typedef logic [1:0] data_size_t;

    // --------------------
    // load operations
    // --------------------

    // the U variants zero-extend, the others sign-extend
    typedef enum logic [2:0] {
        LD,
        LW,
        LWU,
        LH,
        LHU,
        LB,
        LBU
    } load_op_e;

    // size code that the cache needs for a given operation
    function automatic data_size_t transfer_size(load_op_e op);
        case (op)
            LD:       return 2'd3;
            LW, LWU:  return 2'd2;
            LH, LHU:  return 2'd1;
            default:  return 2'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- sim.f
+incdir+logic
logic/load_unit_pkg.sv
logic/load_ctrl_fsm.sv
logic/load_buffer.sv
logic/load_align.sv
logic/load_unit.sv
verif/tb_load_unit.sv

//--- verif/tb_load_unit.sv
// Load unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_load_unit;
    import load_unit_pkg::*;

    localparam int unsigned NUM_LOADS = 400;
    localparam int unsigned TIMEOUT   = 1000;
    localparam int unsigned NR_IDS    = 1 << $bits(trans_id_t);
    // every page is moved by the same distance, so the page offset is kept
    localparam paddr_t      PAGE_DELTA = 56'h1234_5000;

    typedef enum logic [1:0] {RESP_NONE, RESP_KILL, RESP_LIVE, RESP_FLUSHED} resp_e;

    logic       clk;
    logic       rst_n;
    logic       flush;
    logic       ld_valid;
    vaddr_t     ld_vaddr;
    load_op_e   ld_op;
    trans_id_t  ld_tid;
    logic       pop_ld;
    logic       res_valid;
    trans_id_t  res_tid;
    xlen_t      result;
    logic       translation_req;
    vaddr_t     vaddr_out;
    paddr_t     paddr;
    logic       dtlb_hit;
    dc_index_t  page_offset;
    logic       offset_match;
    logic       data_req;
    logic       data_gnt;
    dc_index_t  address_index;
    data_size_t data_size;
    ldbuf_id_t  data_id;
    logic       tag_valid;
    dc_tag_t    address_tag;
    logic       kill_req;
    logic       data_rvalid;
    ldbuf_id_t  data_rid;
    xlen_t      data_rdata;

    // scoreboard keyed by trans_id
    logic        id_busy  [NR_IDS];
    vaddr_t      sb_vaddr [NR_IDS];
    load_op_e    sb_op    [NR_IDS];
    // requests the cache model still has to answer
    ldbuf_id_t   q_rid[$];
    trans_id_t   q_tid[$];
    int unsigned q_delay[$];
    logic        q_flushed[$];
    // request accepted in the previous cycle, now in its tag phase
    logic        acc_pending;
    logic        acc_hit;
    ldbuf_id_t   acc_id;
    trans_id_t   acc_tid;
    // what the cache is answering in the current cycle
    resp_e       resp_kind;
    trans_id_t   resp_tid;
    int unsigned errors, timeouts, popped, completed, flushed_cnt, aborts, reordered;

    // --------------------
    // models and reference
    // --------------------

    function automatic paddr_t translate(vaddr_t va);
        return paddr_t'(va) + PAGE_DELTA;
    endfunction

    // memory contents, a hash of the whole word address
    function automatic xlen_t mem_word(paddr_t pa);
        logic [63:0] x;
        x = {8'h00, pa[55:3], 3'b000};
        x = x ^ (x >> 31);
        x = x * 64'h9e37_79b9_7f4a_7c15;
        x = x ^ (x >> 29);
        return x;
    endfunction

    function automatic data_size_t size_code(load_op_e op);
        case (op)
            LD:      return 2'd3;
            LW, LWU: return 2'd2;
            LH, LHU: return 2'd1;
            default: return 2'd0;
        endcase
    endfunction

    // the field starts at the byte offset, and the U loads fill with zeros
    function automatic xlen_t ref_result(load_op_e op, logic [2:0] off, xlen_t word);
        xlen_t f;
        f = word >> (8 * off);
        case (op)
            LW:      return {{32{f[31]}}, f[31:0]};
            LWU:     return {32'h0, f[31:0]};
            LH:      return {{48{f[15]}}, f[15:0]};
            LHU:     return {48'h0, f[15:0]};
            LB:      return {{56{f[7]}}, f[7:0]};
            LBU:     return {56'h0, f[7:0]};
            default: return f;
        endcase
    endfunction

    task automatic report_failure(string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        errors++;
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic report_timeout(string msg);
        timeouts++;
        $display("timeout at %0t: %s", $time, msg);
    endtask

    // the TLB answers from the address the DUT forwards
    assign paddr = translate(vaddr_out);

    load_unit dut (
        .clk_i                 (clk),
        .rst_ni                (rst_n),
        .flush_i               (flush),
        .valid_i               (ld_valid),
        .vaddr_i               (ld_vaddr),
        .op_i                  (ld_op),
        .trans_id_i            (ld_tid),
        .pop_ld_o              (pop_ld),
        .valid_o               (res_valid),
        .trans_id_o            (res_tid),
        .result_o              (result),
        .translation_req_o     (translation_req),
        .vaddr_o               (vaddr_out),
        .paddr_i               (paddr),
        .dtlb_hit_i            (dtlb_hit),
        .page_offset_o         (page_offset),
        .page_offset_matches_i (offset_match),
        .data_req_o            (data_req),
        .data_gnt_i            (data_gnt),
        .address_index_o       (address_index),
        .data_size_o           (data_size),
        .data_id_o             (data_id),
        .tag_valid_o           (tag_valid),
        .address_tag_o         (address_tag),
        .kill_req_o            (kill_req),
        .data_rvalid_i         (data_rvalid),
        .data_rid_i            (data_rid),
        .data_rdata_i          (data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // --------------------
    // random side inputs
    // --------------------
    task automatic run_side_inputs();
        int unsigned burst;
        burst = 0;
        forever begin
            @(posedge clk);
            #2;
            dtlb_hit = ($urandom % 5) != 0;
            // a pending store to the same offset lasts a few cycles
            if (burst > 0) begin
                burst--;
            end else if (($urandom % 12) == 0) begin
                burst = 1 + $urandom % 4;
            end
            offset_match = burst > 0;
        end
    endtask

    // samples the port at the falling edge and answers after the next rising edge
    task automatic run_cache_model();
        int     ready[$];
        int     pick;
        paddr_t exp_pa;
        logic   kill_next;
        kill_next = 1'b0;
        forever begin
            @(negedge clk);
            if (resp_kind == RESP_LIVE || resp_kind == RESP_FLUSHED) begin
                id_busy[resp_tid] = 1'b0;
            end
            if (acc_pending) begin
                exp_pa = translate(sb_vaddr[acc_tid]);
                assert (tag_valid) else report_failure("no tag_valid_o after a granted request");
                assert (address_tag == exp_pa[$bits(paddr_t)-1:$bits(dc_index_t)])
                    else report_mismatch("address_tag_o", address_tag,
                                         exp_pa[$bits(paddr_t)-1:$bits(dc_index_t)]);
                if (acc_hit) begin
                    assert (!kill_req) else report_failure("kill_req_o for a load that hit");
                end else begin
                    assert (kill_req) else report_failure("no kill_req_o after a TLB miss");
                end
            end else if (tag_valid) begin
                assert (kill_req) else report_failure("tag_valid_o without a granted request");
            end
            // loads in flight at a flush must stay silent
            if (flush) begin
                foreach (q_flushed[i]) begin
                    q_flushed[i] = 1'b1;
                end
            end
            // the store side compares against the offset of the held load
            if (ld_valid) begin
                assert (page_offset == ld_vaddr[$bits(dc_index_t)-1:0])
                    else report_mismatch("page_offset_o", page_offset,
                                         ld_vaddr[$bits(dc_index_t)-1:0]);
            end
            acc_pending = data_req && data_gnt;
            kill_next   = 1'b0;
            if (acc_pending) begin
                acc_hit = pop_ld;
                acc_id  = data_id;
                acc_tid = ld_tid;
                assert (pop_ld == dtlb_hit) else report_mismatch("pop_ld_o", pop_ld, dtlb_hit);
                assert (translation_req)
                    else report_failure("no translation_req_o on an accepted request");
                assert (data_size == size_code(ld_op))
                    else report_mismatch("data_size_o", data_size, size_code(ld_op));
                assert (address_index == ld_vaddr[$bits(dc_index_t)-1:0])
                    else report_mismatch("address_index_o", address_index,
                                         ld_vaddr[$bits(dc_index_t)-1:0]);
                if (pop_ld) begin
                    popped++;
                    q_rid.push_back(data_id);
                    q_tid.push_back(ld_tid);
                    q_delay.push_back(2 + $urandom % 6);
                    q_flushed.push_back(1'b0);
                end else begin
                    aborts++;
                    kill_next = 1'b1;
                end
            end else begin
                assert (!pop_ld) else report_failure("pop_ld_o without an accepted request");
            end

            @(posedge clk);
            #2;
            data_gnt = ($urandom % 4) != 0;
            foreach (q_delay[i]) begin
                if (q_delay[i] > 0) begin
                    q_delay[i]--;
                end
            end
            ready.delete();
            foreach (q_delay[i]) begin
                if (q_delay[i] == 0) begin
                    ready.push_back(i);
                end
            end
            // the killed request is answered in the kill cycle, ahead of the rest
            if (kill_next) begin
                data_rvalid = 1'b1;
                data_rid    = acc_id;
                data_rdata  = {$urandom, $urandom};
                resp_kind   = RESP_KILL;
                resp_tid    = acc_tid;
            end else if (ready.size() > 0) begin
                pick = ready[$urandom % ready.size()];
                if (pick != 0) begin
                    reordered++;
                end
                resp_tid    = q_tid[pick];
                data_rvalid = 1'b1;
                data_rid    = q_rid[pick];
                data_rdata  = mem_word(translate(sb_vaddr[resp_tid]));
                resp_kind   = q_flushed[pick] ? RESP_FLUSHED : RESP_LIVE;
                q_rid.delete(pick);
                q_tid.delete(pick);
                q_delay.delete(pick);
                q_flushed.delete(pick);
            end else begin
                data_rvalid = 1'b0;
                resp_kind   = RESP_NONE;
            end
        end
    endtask

    // --------------------
    // result checker
    // --------------------
    always @(negedge clk) begin : compare_results
        xlen_t expected;
        if (rst_n) begin
            if (resp_kind == RESP_LIVE) begin
                expected = ref_result(sb_op[resp_tid], sb_vaddr[resp_tid][2:0],
                                      mem_word(translate(sb_vaddr[resp_tid])));
                assert (res_valid) else report_failure("no valid_o for a live response");
                assert (res_tid == resp_tid) else report_mismatch("trans_id_o", res_tid, resp_tid);
                assert (result == expected) else report_mismatch("result_o", result, expected);
                completed++;
            end else begin
                assert (!res_valid)
                    else report_failure("valid_o for a killed or flushed load, or no response");
                if (resp_kind == RESP_FLUSHED) begin
                    flushed_cnt++;
                end
            end
        end
    end

    // --------------------
    // issue side
    // --------------------
    task automatic issue_load();
        trans_id_t   tid;
        load_op_e    op;
        logic [2:0]  off;
        vaddr_t      va;
        int unsigned waited;
        @(posedge clk);
        #2;
        waited = 0;
        tid    = trans_id_t'($urandom);
        while (id_busy[tid] && waited < TIMEOUT) begin
            waited++;
            @(posedge clk);
            #2;
            tid = trans_id_t'($urandom);
        end
        if (id_busy[tid]) begin
            report_timeout("no free trans_id for a new load");
            return;
        end
        // only naturally aligned offsets are legal
        op  = load_op_e'($urandom % 7);
        off = 3'($urandom);
        case (op)
            LD:      off = 3'b000;
            LW, LWU: off = off & 3'b100;
            LH, LHU: off = off & 3'b110;
            default: off = off;
        endcase
        va       = vaddr_t'({$urandom, $urandom});
        va[2:0]  = off;
        sb_vaddr[tid] = va;
        sb_op[tid]    = op;
        id_busy[tid]  = 1'b1;
        ld_valid = 1'b1;
        ld_vaddr = va;
        ld_op    = op;
        ld_tid   = tid;
        waited   = 0;
        @(negedge clk);
        while (!pop_ld && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!pop_ld) begin
            report_timeout("pop_ld_o never came for a held load");
            return;
        end
        // the tag goes out in the next cycle, so the address is held one more cycle
        @(posedge clk);
        #2;
        ld_valid = 1'b0;
        if (($urandom % 25) == 0) begin
            @(posedge clk);
            #2;
            flush = 1'b1;
            @(posedge clk);
            #2;
            flush = 1'b0;
        end
    endtask

    task automatic drain_outstanding();
        int unsigned waited;
        waited = 0;
        @(negedge clk);
        while ((q_rid.size() != 0 || resp_kind != RESP_NONE) && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (q_rid.size() != 0 || resp_kind != RESP_NONE) begin
            report_timeout("cache responses still outstanding at the end");
        end
    endtask

    task automatic finish_run();
        $write("popped %0d, completed %0d, flushed %0d, aborts %0d, ",
               popped, completed, flushed_cnt, aborts);
        $display("reordered %0d, errors %0d, timeouts %0d", reordered, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    initial begin : main
        void'($urandom(32'hf7d7b6ab));
        rst_n        = 1'b0;
        flush        = 1'b0;
        ld_valid     = 1'b0;
        ld_vaddr     = '0;
        ld_op        = LD;
        ld_tid       = '0;
        dtlb_hit     = 1'b0;
        offset_match = 1'b0;
        data_gnt     = 1'b0;
        data_rvalid  = 1'b0;
        data_rid     = '0;
        data_rdata   = '0;
        acc_pending  = 1'b0;
        acc_hit      = 1'b0;
        acc_id       = '0;
        acc_tid      = '0;
        resp_kind    = RESP_NONE;
        resp_tid     = '0;
        errors       = 0;
        timeouts     = 0;
        popped       = 0;
        completed    = 0;
        flushed_cnt  = 0;
        aborts       = 0;
        reordered    = 0;
        foreach (id_busy[i]) begin
            id_busy[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // nothing may move before the first load is offered
        repeat (5) begin
            @(negedge clk);
            assert (!(pop_ld || res_valid || data_req || tag_valid || kill_req || translation_req))
                else report_failure("a control output is high with no load issued");
        end
        fork
            run_cache_model();
            run_side_inputs();
        join_none
        for (int n = 0; n < NUM_LOADS && timeouts == 0; n++) begin
            issue_load();
        end
        if (timeouts == 0) begin
            drain_outstanding();
        end
        if (timeouts == 0) begin
            assert (popped == completed + flushed_cnt)
                else report_failure("popped loads and finished loads do not add up");
            // the run must have reached reordering, the abort path and a flush with loads out
            assert (reordered > 0) else report_failure("no response came back out of order");
            assert (aborts > 0) else report_failure("no TLB miss after a grant was seen");
            assert (flushed_cnt > 0) else report_failure("no load was outstanding at a flush");
        end
        finish_run();
    end

endmodule

`default_nettype wire
